// File: ppu_params.svh
`ifndef PPU_PARAMS_SVH
`define PPU_PARAMS_SVH

// frame geometry, one dot per clk
`define DOTS_PER_LINE    341
`define LINES_PER_FRAME  262

// visible window
`define VIS_WIDTH        256
`define VIS_LINES        240        // rows 0..239, row 240 is post-render

// vertical blank
`define VBLANK_LINE      241        // vblank flag set and nmi fired here
`define PRE_LINE         261        // pre-render row, vblank flag cleared
`define NMI_DOTS         3          // nmi_n held low for dots 0..2

// left column clip when bg_left is off
`define CLIP_WIDTH       8

// nametables in the 14-bit PPU address space
`define NT_BASE          14'h2000
`define NT_SIZE          1024       // bytes per table, two tables fitted

// palette RAM, 6-bit colour entries
`define PAL_BASE         14'h3F00
`define PAL_ENTRIES      32

// greyscale keeps only the luma bits
`define GREY_MASK        6'h30

`endif

// File: ppu_pkg.sv
package ppu_pkg;

    // CPU register select, codes 3..5 read as zero
    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_MASK   = 3'd1,
        REG_STATUS = 3'd2,
        REG_ADDR   = 3'd6,
        REG_DATA   = 3'd7
    } ppu_reg_e;

    // vertical phase of the frame
    typedef enum logic [1:0] {
        PRE_SL,
        VIS_SL,
        POST_SL,
        VBLANK_SL
    } vs_state_e;

    // request on the shared memory port
    typedef struct packed {
        logic        req;
        logic        we;
        logic [13:0] addr;
        logic [7:0]  wdata;
    } mem_req_t;

    // current dot, x runs up to 340
    typedef struct packed {
        logic       valid;    // dot is inside the visible window
        logic [8:0] x;
        logic [7:0] y;
    } dot_pos_t;

    // PPUCTRL / PPUMASK fields the renderer and address logic need
    typedef struct packed {
        logic       nt_sel;
        logic       inc32;
        logic       bg_en;
        logic       bg_left;
        logic       grey;
        logic [2:0] spare;
    } ctrl_bits_t;

endpackage

// File: ppu_timing.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_timing
    import ppu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    output dot_pos_t dot,
    output logic     vblank_set,
    output logic     vblank_clr,
    output logic     nmi_n
);

    logic [8:0] row;
    logic [8:0] col;
    logic       last_dot;
    vs_state_e  vs_state;
    vs_state_e  vs_next;

    assign last_dot = (col == 9'(`DOTS_PER_LINE - 1));

    // dot and line counters, start on the pre-render row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row <= 9'(`PRE_LINE);
            col <= '0;
        end else begin
            col <= last_dot ? 9'd0 : col + 9'd1;
            if (last_dot) begin
                row <= (row == 9'(`LINES_PER_FRAME - 1)) ? 9'd0 : row + 9'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_state <= PRE_SL;
        end else begin
            vs_state <= vs_next;
        end
    end

    // state moves on the last dot of rows 261, 239, 240 and 260
    always_comb begin
        vs_next = vs_state;
        case (vs_state)
            PRE_SL:    if (last_dot) vs_next = VIS_SL;
            VIS_SL:    if (last_dot && row == 9'(`VIS_LINES - 1)) vs_next = POST_SL;
            POST_SL:   if (last_dot) vs_next = VBLANK_SL;
            VBLANK_SL: if (last_dot && row == 9'(`PRE_LINE - 1)) vs_next = PRE_SL;
            default:   vs_next = PRE_SL;
        endcase
    end

    assign dot.valid = (vs_state == VIS_SL) && (col < 9'(`VIS_WIDTH));
    assign dot.x     = col;
    assign dot.y     = row[7:0];

    // one-cycle strobes toward the status register
    assign vblank_set = (vs_state == VBLANK_SL) && (row == 9'(`VBLANK_LINE)) && (col == 9'd0);
    assign vblank_clr = (vs_state == PRE_SL) && (col == 9'd0);

    // low for the first dots of the first vblank row only
    assign nmi_n = !((vs_state == VBLANK_SL) && (row == 9'(`VBLANK_LINE)) &&
                     (col < 9'(`NMI_DOTS)));

endmodule

// File: ppu_regs.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_regs
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reg_en,
    input  logic       reg_rw,       // 1 write, 0 read
    input  ppu_reg_e   reg_sel,
    input  logic [7:0] reg_wdata,
    input  logic       vblank_set,
    input  logic       vblank_clr,
    input  logic       cpu_gnt,
    input  logic [7:0] mem_rdata,
    output logic [7:0] reg_rdata,
    output ctrl_bits_t ctrl,
    output mem_req_t   cpu_req
);

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic        vblank;
    logic        addr_latch;         // 0 high byte next, 1 low byte next
    logic [13:0] vaddr;
    logic [7:0]  rd_buf;
    logic [7:0]  pal_buf;            // palette byte at vaddr, fetched ahead
    logic        pal_stale;
    logic        pre_rd;             // pending read is a palette prefetch
    logic        buf_fill;
    logic        pal_fill;
    logic        wr_stb;
    logic        rd_stb;
    logic        status_rd;
    logic        addr_wr;
    logic        data_acc;
    logic        pal_hit;
    logic        req_free;
    logic [13:0] vaddr_inc;

    assign wr_stb    = reg_en && reg_rw;
    assign rd_stb    = reg_en && !reg_rw;
    assign status_rd = rd_stb && (reg_sel == REG_STATUS);
    assign addr_wr   = wr_stb && (reg_sel == REG_ADDR);
    assign data_acc  = reg_en && (reg_sel == REG_DATA);
    assign pal_hit   = (vaddr >= `PAL_BASE);
    assign req_free  = !cpu_req.req || cpu_gnt;   // old request done on this edge
    assign vaddr_inc = ctrl.inc32 ? 14'd32 : 14'd1;

    always_comb begin
        ctrl.nt_sel  = ppuctrl[0];
        ctrl.inc32   = ppuctrl[2];
        ctrl.bg_en   = ppumask[3];
        ctrl.bg_left = ppumask[1];
        ctrl.grey    = ppumask[0];
        ctrl.spare   = 3'b000;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ppuctrl    <= '0;
            ppumask    <= '0;
            vblank     <= 1'b0;
            addr_latch <= 1'b0;
        end else begin
            if (wr_stb && reg_sel == REG_CTRL) ppuctrl <= reg_wdata;
            if (wr_stb && reg_sel == REG_MASK) ppumask <= reg_wdata;
            if (status_rd) begin
                addr_latch <= 1'b0;
            end else if (addr_wr) begin
                addr_latch <= !addr_latch;
            end
            if (status_rd || vblank_clr) begin   // clear wins over set
                vblank <= 1'b0;
            end else if (vblank_set) begin
                vblank <= 1'b1;
            end
        end
    end

    // VRAM address, PPUDATA requests and the read buffers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_req   <= '0;
            vaddr     <= '0;
            rd_buf    <= '0;
            pal_buf   <= '0;
            pal_stale <= 1'b0;
            pre_rd    <= 1'b0;
            buf_fill  <= 1'b0;
            pal_fill  <= 1'b0;
        end else begin
            buf_fill <= cpu_req.req && cpu_gnt && !cpu_req.we && !pre_rd;
            pal_fill <= cpu_req.req && cpu_gnt && pre_rd;
            if (buf_fill) rd_buf <= mem_rdata;     // data one cycle after grant
            if (pal_fill) pal_buf <= mem_rdata;
            if (cpu_gnt) cpu_req.req <= 1'b0;
            if (addr_wr) begin
                if (!addr_latch) begin
                    vaddr[13:8] <= reg_wdata[5:0];
                end else begin
                    vaddr[7:0] <= reg_wdata;
                end
                pal_stale <= 1'b1;
            end else if (data_acc && req_free) begin
                vaddr     <= vaddr + vaddr_inc;
                pal_stale <= 1'b1;
                if (!(rd_stb && pal_hit)) begin    // palette reads skip memory
                    cpu_req <= '{req: 1'b1, we: reg_rw, addr: vaddr, wdata: reg_wdata};
                    pre_rd  <= 1'b0;
                end
            end else if (pal_stale && pal_hit && req_free) begin
                cpu_req   <= '{req: 1'b1, we: 1'b0, addr: vaddr, wdata: 8'h00};
                pre_rd    <= 1'b1;
                pal_stale <= 1'b0;
            end
        end
    end

    always_comb begin
        reg_rdata = 8'h00;
        if (rd_stb) begin
            case (reg_sel)
                REG_CTRL:   reg_rdata = ppuctrl;
                REG_MASK:   reg_rdata = ppumask;
                REG_STATUS: reg_rdata = {vblank, 7'b0000000};
                REG_DATA:   reg_rdata = pal_hit ? pal_buf : rd_buf;
                default:    reg_rdata = 8'h00;
            endcase
        end
    end

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import ppu_pkg::*;
(
    input  mem_req_t bg_req,
    input  mem_req_t cpu_req,
    output logic     bg_gnt,
    output logic     cpu_gnt,
    output mem_req_t mem_req
);

    // renderer always first, it cannot wait during visible dots
    assign bg_gnt  = bg_req.req;
    assign cpu_gnt = cpu_req.req && !bg_req.req;

    // forward the winner, idle port when nobody asks
    always_comb begin
        mem_req = '0;
        if (bg_gnt) begin
            mem_req = bg_req;
        end else if (cpu_gnt) begin
            mem_req = cpu_req;
        end
    end

endmodule

// File: ppu_mem.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module ppu_mem
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  mem_req_t   mem_req,
    input  logic [4:0] pal_idx,
    output logic [7:0] mem_rdata,
    output logic [5:0] pal_color
);

    logic [7:0]  nt_ram  [0:2*`NT_SIZE-1];
    logic [5:0]  pal_ram [0:`PAL_ENTRIES-1];
    logic        pal_sel;
    logic [10:0] nt_addr;
    logic [4:0]  pal_addr;

    // 0x10/0x14/0x18/0x1c share storage with 0x00/0x04/0x08/0x0c
    function automatic logic [4:0] pal_mirror(input logic [4:0] idx);
        return (idx[1:0] == 2'b00) ? {1'b0, idx[3:0]} : idx;
    endfunction

    assign pal_sel  = (mem_req.addr >= `PAL_BASE);
    assign nt_addr  = mem_req.addr[10:0];          // wraps to 2 KB
    assign pal_addr = pal_mirror(mem_req.addr[4:0]);

    always_ff @(posedge clk) begin
        if (mem_req.req && mem_req.we) begin
            if (pal_sel) begin
                pal_ram[pal_addr] <= mem_req.wdata[5:0];
            end else begin
                nt_ram[nt_addr] <= mem_req.wdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rdata <= '0;
        end else if (mem_req.req && !mem_req.we) begin
            mem_rdata <= pal_sel ? {2'b00, pal_ram[pal_addr]} : nt_ram[nt_addr];
        end
    end

    assign pal_color = pal_ram[pal_mirror(pal_idx)];   // renderer lookup, async

endmodule

// File: bg_render.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module bg_render
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  dot_pos_t   dot,
    input  ctrl_bits_t ctrl,
    input  logic       bg_gnt,
    input  logic [7:0] mem_rdata,
    input  logic [5:0] pal_color,
    output mem_req_t   bg_req,
    output logic [4:0] pal_idx,
    output logic       pix_valid,
    output logic [7:0] pix_x,
    output logic [7:0] pix_y,
    output logic [5:0] pix_color
);

    logic [13:0] nt_off;
    dot_pos_t    s1_pos;
    logic        s1_hit;      // nametable byte arrives this cycle
    logic [3:0]  idx;

    // stage 1, tile fetch from the selected nametable
    assign nt_off = ctrl.nt_sel ? 14'(`NT_SIZE) : 14'd0;

    always_comb begin
        bg_req.req   = dot.valid;
        bg_req.we    = 1'b0;
        bg_req.addr  = `NT_BASE + nt_off + {4'b0000, dot.y[7:3], dot.x[7:3]};
        bg_req.wdata = 8'h00;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_pos <= '0;
            s1_hit <= 1'b0;
        end else begin
            s1_pos <= dot;
            s1_hit <= bg_req.req && bg_gnt;
        end
    end

    // stage 2, mask rules then palette index
    always_comb begin
        idx = s1_hit ? mem_rdata[3:0] : 4'h0;
        if (!ctrl.bg_en) idx = 4'h0;
        if (!ctrl.bg_left && s1_pos.x < 9'(`CLIP_WIDTH)) idx = 4'h0;   // left clip
        if (idx[1:0] == 2'b00) idx = 4'h0;                            // transparent
    end

    assign pal_idx = {1'b0, idx};    // background half of the palette

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
            pix_x     <= '0;
            pix_y     <= '0;
            pix_color <= '0;
        end else begin
            pix_valid <= s1_pos.valid;
            pix_x     <= s1_pos.x[7:0];
            pix_y     <= s1_pos.y;
            pix_color <= ctrl.grey ? (pal_color & `GREY_MASK) : pal_color;
        end
    end

endmodule

// File: ppu_top.sv
`timescale 1ns/1ps

module ppu_top
    import ppu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       reg_en,
    input  logic       reg_rw,
    input  ppu_reg_e   reg_sel,
    input  logic [7:0] reg_wdata,
    output logic [7:0] reg_rdata,
    output logic       nmi_n,
    output logic       pix_valid,
    output logic [7:0] pix_x,
    output logic [7:0] pix_y,
    output logic [5:0] pix_color
);

    dot_pos_t   dot;
    logic       vblank_set;
    logic       vblank_clr;
    ctrl_bits_t ctrl;
    mem_req_t   cpu_req;
    mem_req_t   bg_req;
    mem_req_t   mem_req;
    logic       cpu_gnt;
    logic       bg_gnt;
    logic [7:0] mem_rdata;     // shared by both peers
    logic [4:0] pal_idx;
    logic [5:0] pal_color;

    ppu_timing u_timing (
        .clk, .rst_n, .dot, .vblank_set, .vblank_clr, .nmi_n
    );

    ppu_regs u_regs (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_wdata,
        .vblank_set, .vblank_clr, .cpu_gnt, .mem_rdata,
        .reg_rdata, .ctrl, .cpu_req
    );

    mem_arbiter u_arb (
        .bg_req, .cpu_req, .bg_gnt, .cpu_gnt, .mem_req
    );

    ppu_mem u_mem (
        .clk, .rst_n, .mem_req, .pal_idx, .mem_rdata, .pal_color
    );

    bg_render u_bg (
        .clk, .rst_n, .dot, .ctrl, .bg_gnt, .mem_rdata, .pal_color,
        .bg_req, .pal_idx, .pix_valid, .pix_x, .pix_y, .pix_color
    );

endmodule

// File: tb_ppu.sv
`timescale 1ns/1ps
`include "ppu_params.svh"

module tb_ppu
    import ppu_pkg::*;
();

    localparam int FRAME_CYCLES = `DOTS_PER_LINE * `LINES_PER_FRAME;
    localparam int VIS_DOTS     = `VIS_WIDTH * `VIS_LINES;
    // dot 0 of row 241, counted from row 261 dot 0 right after reset
    localparam int FIRST_NMI_CYCLE =
        (`LINES_PER_FRAME - `PRE_LINE + `VBLANK_LINE) * `DOTS_PER_LINE;

    logic       clk;
    logic       rst_n;
    logic       reg_en;
    logic       reg_rw;
    ppu_reg_e   reg_sel;
    logic [7:0] reg_wdata;
    logic [7:0] reg_rdata;
    logic       nmi_n;
    logic       pix_valid;
    logic [7:0] pix_x;
    logic [7:0] pix_y;
    logic [5:0] pix_color;

    // memory and register image built from the CPU writes
    logic [7:0]  nt_model   [0:2*`NT_SIZE-1];
    bit          nt_written [0:2*`NT_SIZE-1];
    logic [5:0]  pal_model  [0:`PAL_ENTRIES-1];
    logic [7:0]  m_ctrl;
    logic [7:0]  m_mask;
    logic [13:0] m_addr;
    logic        m_latch;
    logic [31:0] lcg_state;
    int          frame_budget = 0;
    int          spot_x[$];         // pixel spots from the test file
    int          spot_y[$];
    int          spot_c[$];
    bit          seen [0:65535];
    int          nmi_low = 0;
    int          cyc = 0;
    int          last_fall = 0;
    logic        nmi_prev = 1'b1;

    ppu_top i_dut (
        .clk, .rst_n, .reg_en, .reg_rw, .reg_sel, .reg_wdata,
        .reg_rdata, .nmi_n, .pix_valid, .pix_x, .pix_y, .pix_color
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // 0x10/0x14/0x18/0x1c share storage with 0x00/0x04/0x08/0x0c
    function automatic int pal_slot(input logic [4:0] idx);
        if (idx[4] && idx[1:0] == 2'b00) return int'(idx[3:0]);
        return int'(idx);
    endfunction

    function automatic void model_write(input logic [13:0] addr, input logic [7:0] data);
        if (addr >= `PAL_BASE) begin
            pal_model[pal_slot(addr[4:0])] = data[5:0];
        end else begin
            nt_model[addr[10:0]]   = data;     // 2 KB wrap
            nt_written[addr[10:0]] = 1'b1;
        end
    endfunction

    function automatic logic [5:0] model_pixel(input int x, input int y);
        logic [7:0] tile;
        logic [3:0] idx;
        logic [5:0] colour;
        tile = nt_model[(m_ctrl[0] ? `NT_SIZE : 0) + (y / 8) * 32 + x / 8];
        idx  = tile[3:0];
        if (!m_mask[3]) idx = 4'h0;                       // background off
        if (!m_mask[1] && x < `CLIP_WIDTH) idx = 4'h0;
        if (idx[1:0] == 2'b00) idx = 4'h0;
        colour = pal_model[pal_slot({1'b0, idx})];
        if (m_mask[0]) colour = colour & `GREY_MASK;
        return colour;
    endfunction

    // one-cycle strobe plus room for the buffer refill on reads
    task automatic reg_access(input logic rw, input logic [2:0] sel, input logic [7:0] wdata,
                              output logic [7:0] rdata);
        @(posedge clk);
        reg_en    <= 1'b1;
        reg_rw    <= rw;
        reg_sel   <= ppu_reg_e'(sel);
        reg_wdata <= wdata;
        @(negedge clk);
        rdata = reg_rdata;
        @(posedge clk);
        reg_en <= 1'b0;
        if (!rw) repeat (2) @(posedge clk);
    endtask

    task automatic write_reg(input logic [2:0] sel, input logic [7:0] data);
        logic [7:0] ignored;
        reg_access(1'b1, sel, data, ignored);
        case (sel)
            3'd0: m_ctrl = data;
            3'd1: m_mask = data;
            3'd6: begin
                if (!m_latch) m_addr[13:8] = data[5:0];
                else m_addr[7:0] = data;
                m_latch = !m_latch;
            end
            3'd7: begin
                model_write(m_addr, data);
                m_addr = m_addr + (m_ctrl[2] ? 14'd32 : 14'd1);
            end
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [2:0] sel, input logic [7:0] expected);
        logic [7:0] got;
        reg_access(1'b0, sel, 8'h00, got);
        check_equal($sformatf("reg_rdata (reg %0d)", sel), got, expected);
        if (sel == 3'd2) m_latch = 1'b0;
        if (sel == 3'd7) m_addr = m_addr + (m_ctrl[2] ? 14'd32 : 14'd1);
    endtask

    // returns once the nmi pulse of the next vblank is over
    task automatic wait_vblank();
        @(negedge clk);
        while (nmi_n) @(negedge clk);
        while (!nmi_n) @(negedge clk);
    endtask

    // random bytes go only where the test wrote nothing
    task automatic fill_nametables();
        logic [13:0] addr;
        bit          aimed;
        aimed = 1'b0;
        for (int i = 0; i < 2 * `NT_SIZE; i++) begin
            addr = `NT_BASE + 14'(i);
            if (nt_written[i]) begin
                aimed = 1'b0;                  // step over, re-aim after it
            end else begin
                if (!aimed) begin
                    write_reg(3'd6, {2'b00, addr[13:8]});
                    write_reg(3'd6, addr[7:0]);
                    aimed = 1'b1;
                end
                write_reg(3'd7, lcg_byte());
            end
        end
    endtask

    task automatic check_frame();
        int count;
        int cycles;
        int pos;
        count  = 0;
        cycles = 0;
        for (int i = 0; i < 65536; i++) seen[i] = 1'b0;
        @(negedge clk);
        while (!(pix_valid && pix_x == 8'd0 && pix_y == 8'd0)) @(negedge clk);
        while (count < VIS_DOTS) begin
            if (pix_valid) begin
                pos = int'(pix_y) * 256 + int'(pix_x);
                if (pix_y >= `VIS_LINES || seen[pos]) begin
                    abort_run($sformatf("pixel (%0d,%0d) came twice or off screen", pix_x, pix_y));
                end
                seen[pos] = 1'b1;
                count++;
                check_equal($sformatf("pix_color at (%0d,%0d)", pix_x, pix_y), pix_color,
                            model_pixel(pix_x, pix_y));
                foreach (spot_x[k]) begin
                    if (spot_x[k] == pix_x && spot_y[k] == pix_y) begin
                        check_equal($sformatf("pix_color at (%0d,%0d)", pix_x, pix_y),
                                    pix_color, spot_c[k]);
                    end
                end
            end
            if (count < VIS_DOTS) begin
                @(negedge clk);
                cycles++;
                if (cycles > FRAME_CYCLES) abort_run("a frame ended with visible dots missing");
            end
        end
        spot_x.delete();
        spot_y.delete();
        spot_c.delete();
    endtask

    // nmi pulse width, position and one pulse per frame
    always @(negedge clk) begin
        if (rst_n) begin
            if (!nmi_n && nmi_prev) begin
                if (last_fall > 0) begin
                    check_equal("nmi_n period", cyc - last_fall, FRAME_CYCLES);
                end else begin
                    check_equal("nmi_n first fall cycle", cyc, FIRST_NMI_CYCLE);
                end
                last_fall = cyc;
            end
            if (!nmi_n) begin
                nmi_low++;
            end else if (nmi_low != 0) begin
                check_equal("nmi_n low cycles", nmi_low, `NMI_DOTS);
                nmi_low = 0;
            end
            nmi_prev = nmi_n;
            cyc++;
        end
    end

    initial begin
        wait (frame_budget > 0);
        repeat ((frame_budget + 1) * FRAME_CYCLES) @(posedge clk);
        abort_run("Timeout: the tests ran past their frame budget");
    end

    initial begin
        int             fd;
        int             code;
        int             n;
        bit             done;
        logic [127:0]   word;
        logic [8*200-1:0] line;
        logic [15:0]    addr;
        logic [7:0]     a;
        logic [7:0]     b;
        logic [7:0]     c;
        rst_n     = 1'b0;
        reg_en    = 1'b0;
        reg_rw    = 1'b0;
        reg_sel   = REG_CTRL;
        reg_wdata = 8'h00;
        m_ctrl    = 8'h00;
        m_mask    = 8'h00;
        m_addr    = '0;
        m_latch   = 1'b0;
        lcg_state = 32'd5;
        done      = 1'b0;
        fd = $fopen("ppu_tests.txt", "r");
        if (fd == 0) abort_run("cannot open ppu_tests.txt");
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        while (!done) begin
            code = $fscanf(fd, "%s", word);
            if (code != 1) begin
                done = 1'b1;
            end else if (word == "#") begin
                code = $fgets(line, fd);
            end else if (word == "frames") begin
                code = $fscanf(fd, "%d", frame_budget);
            end else if (frame_budget == 0) begin
                abort_run("the test file does not start with its frame count");
            end else if (word == "vbl") begin
                wait_vblank();
            end else if (word == "addr") begin
                code = $fscanf(fd, "%h", addr);
                write_reg(3'd6, addr[15:8]);
                write_reg(3'd6, addr[7:0]);
            end else if (word == "wr") begin
                code = $fscanf(fd, "%h %h", a, b);
                write_reg(a[2:0], b);
            end else if (word == "seq") begin
                code = $fscanf(fd, "%d", n);
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", b);
                    write_reg(3'd7, b);
                end
            end else if (word == "rd") begin
                code = $fscanf(fd, "%h %h", a, b);
                read_reg(a[2:0], b);
            end else if (word == "rdd") begin
                code = $fscanf(fd, "%d", n);
                for (int i = 0; i < n; i++) begin
                    code = $fscanf(fd, "%h", b);
                    read_reg(3'd7, b);
                end
            end else if (word == "fill") begin
                fill_nametables();
            end else if (word == "pix") begin
                code = $fscanf(fd, "%h %h %h", a, b, c);
                spot_x.push_back(a);
                spot_y.push_back(b);
                spot_c.push_back(c);
            end else if (word == "frame") begin
                check_frame();
            end else begin
                abort_run("unknown command in ppu_tests.txt");
            end
        end
        $fclose(fd);
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: ppu_tests.txt
# one command per line, operands hex except the counts after frames, seq and rdd
# vbl | addr A | wr REG D | seq N D.. | rd REG EXP | rdd N EXP.. | fill | pix X Y COLOUR | frame
frames 6
vbl
rd 2 80
rd 2 00
addr 3f00
seq 16 0f 01 02 03 0f 15 16 17 0f 29 2a 2b 0f 31 32 33
addr 2040
seq 4 11 26 3b 4c
addr 2040
rdd 4 00 11 26 3b
wr 0 04
rd 0 04
wr 6 3f
rd 2 00
addr 2100
seq 3 5d 6e 7f
addr 2100
rdd 3 4c 5d 6e
wr 0 00
vbl
fill
wr 1 0a
pix 00 10 01
pix 08 10 16
pix 10 14 2b
pix 18 17 0f
pix 00 40 31
pix 07 50 33
frame
vbl
addr 3f10
seq 1 21
wr 1 08
pix 00 10 21
pix 08 10 16
frame
vbl
wr 1 00
pix 08 10 21
frame
vbl
addr 2440
seq 1 2a
wr 0 01
wr 1 0b
pix 00 10 20
frame

// File: tb.f
+incdir+.
ppu_pkg.sv
ppu_timing.sv
ppu_regs.sv
mem_arbiter.sv
ppu_mem.sv
bg_render.sv
ppu_top.sv
tb_ppu.sv
